// File: list.f
+incdir+verilog
verilog/wb_side_pkg.sv
verilog/flash_side_pkg.sv
verilog/flash_req_if.sv
verilog/wb_reg_decode.sv
verilog/flash_sequencer.sv
verilog/flash_ctrl_top.sv
tests/tb_clock_gen.sv
tests/flash_macro_model.sv
tests/flash_ctrl_asserts.sv
tests/flash_ctrl_tb.sv

// File: tests/flash_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_defines.svh"

module flash_ctrl_tb;

  localparam int NUM_XFERS   = 32;               // bus transfers issued below, rounded up
  localparam int XFER_CYCLES = 2 * (4 + 2) + 6;  // two phases at worst busy, plus ack
  localparam int WATCHDOG_NS = (NUM_XFERS * XFER_CYCLES + 40) * 40;
  localparam logic [15:0] PAGE_A = 16'd5;
  localparam logic [15:0] PAGE_B = 16'd9;
  localparam logic [15:0] PAGE_C = 16'd12;
  localparam logic [15:0] PAGE_D = 16'd20;
  localparam logic [15:0] STATUS_ADDR = 16'h0abc;

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [15:0] adr;
  logic [15:0] dat_w;
  logic [15:0] dat_r;
  logic        ack;
  logic        fm_clk;
  logic        fm_reset_n;
  logic [16:0] fm_addr;
  logic [15:0] fm_wd;
  logic [15:0] fm_rd;
  logic        fm_ren;
  logic        fm_wen;
  logic        fm_prog;
  logic        fm_pstat;
  logic        fm_busy;
  logic [1:0]  fm_status;
  logic        err_inject;
  int          prog_count;
  logic [16:0] last_prog;
  logic [31:0] lcg_state;
  logic [15:0] shadow [0:65535];  // expected flash contents
  int          pstat_count = 0;
  logic [16:0] pstat_addr;

  tb_clock_gen u_clk (.clk_o(clk), .rst_o(rst));

  flash_ctrl_top u_dut (
    .wb_clk_i (clk), .wb_rst_i (rst), .wb_cyc_i (cyc), .wb_stb_i (stb),
    .wb_we_i (we), .wb_adr_i (adr), .wb_dat_i (dat_w), .wb_dat_o (dat_r),
    .wb_ack_o (ack), .fm_clk_o (fm_clk), .fm_reset_o (fm_reset_n),
    .fm_addr_o (fm_addr), .fm_wd_o (fm_wd), .fm_ren_o (fm_ren), .fm_wen_o (fm_wen),
    .fm_program_o (fm_prog), .fm_pagestatus_o (fm_pstat), .fm_rd_i (fm_rd),
    .fm_busy_i (fm_busy), .fm_status_i (fm_status)
  );

  flash_macro_model u_model (
    .clk_i (fm_clk), .rst_n_i (fm_reset_n), .addr_i (fm_addr), .wd_i (fm_wd),
    .ren_i (fm_ren), .wen_i (fm_wen), .program_i (fm_prog), .pagestatus_i (fm_pstat),
    .err_inject_i (err_inject), .rd_o (fm_rd), .busy_o (fm_busy), .status_o (fm_status),
    .prog_count_o (prog_count), .last_prog_o (last_prog)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [15:0] fill_word(input logic [15:0] a);
    return (a * 16'd7) ^ 16'h3c5a;  // initial contents of the macro array
  endfunction

  task automatic check_equal(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // classic single cycle, held until ack
  task automatic wb_cycle(input logic write, input logic [15:0] addr,
                          input logic [15:0] wdata, output logic [15:0] rdata);
    @(posedge clk);
    #5;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = addr;
    dat_w = wdata;
    do begin
      @(posedge clk);
      #5;
    end while (!ack);
    rdata = dat_r;
    @(posedge clk);  // slave sees its ack taken on this edge
    #5;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
  endtask

  task automatic flash_write(input logic [15:0] faddr, input logic [15:0] data);
    logic [15:0] unused;
    wb_cycle(1'b1, faddr + `FC_REG_WINDOW, data, unused);
    shadow[faddr] = data;
  endtask

  task automatic flash_read_check(input string name, input logic [15:0] faddr);
    logic [15:0] rd;
    wb_cycle(1'b0, faddr + `FC_REG_WINDOW, 16'h0, rd);
    check_equal(name, shadow[faddr], rd);
  endtask

  task automatic reg_write(input logic [5:0] ofs, input logic [15:0] data);
    logic [15:0] unused;
    wb_cycle(1'b1, {10'b0, ofs}, data, unused);
  endtask

  task automatic reg_read_check(input string name, input logic [5:0] ofs,
                                input logic [15:0] exp);
    logic [15:0] rd;
    wb_cycle(1'b0, {10'b0, ofs}, 16'h0, rd);
    check_equal(name, exp, rd);
  endtask

  always @(negedge clk) begin
    if (fm_pstat) begin
      pstat_count <= pstat_count + 1;
      pstat_addr  <= fm_addr;
    end
  end

  always @(negedge clk) begin
    if (u_dut.u_asserts.fail_count != 0) begin
      $display("a protocol assertion bound to the DUT failed");
      $display("Checks failed");
      $fatal(1, "protocol assertion");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the DUT stopped answering", WATCHDOG_NS);
    $display("Checks failed");
    $fatal(1, "watchdog");
  end

  initial begin : stimulus
    int          i;
    int          base;
    logic [15:0] faddr;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    dat_w      = '0;
    err_inject = 1'b0;
    lcg_state  = 32'd55;
    for (i = 0; i < 65536; i++) begin
      shadow[i] = fill_word(i[15:0]);
    end
    @(negedge clk);
    check_equal("reset_macro", 16'h0000, {15'b0, fm_reset_n});  // macro held in reset
    @(negedge rst);
    repeat (3) begin  // bus and macro stay quiet after reset
      @(negedge clk);
      check_equal("reset_idle", 16'h0020,
                  {10'b0, fm_reset_n, ack, fm_ren, fm_wen, fm_prog, fm_pstat});
    end
    reg_read_check("reset_status", `FC_REG_FLASH_STATUS, 16'h0007);
    reg_read_check("reset_dirty", `FC_REG_DIRTY_PAGE, 16'hffff);

    base = prog_count;
    for (i = 0; i < 4; i++) begin
      lcg_state = lcg_next(lcg_state);
      flash_write(PAGE_A * 64 + i * 5, lcg_state[31:16]);
    end
    for (i = 0; i < 4; i++) begin
      flash_read_check("same_page_read", PAGE_A * 64 + i * 5);
    end
    check_equal("same_page_no_program", base[15:0], prog_count[15:0]);
    reg_read_check("dirty_after_write", `FC_REG_DIRTY_PAGE, PAGE_A);

    flash_read_check("other_page_read", PAGE_B * 64 + 16'd17);
    check_equal("page_change_programs", base[15:0] + 16'd1, prog_count[15:0]);
    check_equal("program_at_old_page", PAGE_A * 64, last_prog[15:0]);
    reg_read_check("dirty_after_commit", `FC_REG_DIRTY_PAGE, 16'hffff);
    for (i = 0; i < 4; i++) begin
      faddr = PAGE_A * 64 + i * 5;
      check_equal("model_array", shadow[faddr], u_model.mem[faddr]);
      flash_read_check("reread_old_page", faddr);
    end
    check_equal("clean_reads_no_program", base[15:0] + 16'd1, prog_count[15:0]);

    flash_write(PAGE_C * 64 + 16'd3, 16'h1234);
    reg_read_check("dirty_before_sync", `FC_REG_DIRTY_PAGE, PAGE_C);
    reg_write(`FC_REG_DIRTY_SYNC, 16'h0001);
    check_equal("sync_programs", base[15:0] + 16'd2, prog_count[15:0]);
    check_equal("sync_address", PAGE_C * 64, last_prog[15:0]);
    reg_read_check("dirty_after_sync", `FC_REG_DIRTY_PAGE, 16'hffff);
    reg_read_check("status_after_sync", `FC_REG_FLASH_STATUS, 16'h0000);

    base = pstat_count;
    reg_write(`FC_REG_PAGE_STATUS, STATUS_ADDR);
    reg_read_check("page_status_reply", `FC_REG_PAGE_STATUS,
                   16'hc000 | {6'b0, STATUS_ADDR[15:6]});
    check_equal("page_status_strobes", base[15:0] + 16'd1, pstat_count[15:0]);
    check_equal("page_status_address", STATUS_ADDR, pstat_addr[15:0]);

    flash_write(PAGE_D * 64 + 16'd40, 16'hbeef);
    err_inject = 1'b1;
    reg_write(`FC_REG_DIRTY_SYNC, 16'h0001);
    err_inject = 1'b0;
    reg_read_check("dirty_after_failed_sync", `FC_REG_DIRTY_PAGE, PAGE_D);
    reg_read_check("status_after_failed_sync", `FC_REG_FLASH_STATUS, 16'h0001);

    @(negedge clk);
    if (u_dut.u_asserts.fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "protocol assertion at end of run");
    end
  end

endmodule

`default_nettype wire

// File: tests/flash_ctrl_asserts.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_defines.svh"

module flash_ctrl_asserts (
  input logic                    wb_clk_i,
  input logic                    wb_rst_i,
  input logic                    wb_cyc_i,
  input logic                    wb_stb_i,
  input logic                    wb_ack_o,
  input logic                    fm_ren_o,
  input logic                    fm_wen_o,
  input logic                    fm_program_o,
  input logic                    fm_pagestatus_o,
  input logic [`FC_FM_ADR_W-1:0] fm_addr_o,
  input logic                    dirty_i,
  input logic [`FC_PAGE_BITS-1:0] dirty_page_i
);

  int fail_count = 0;  // polled by the testbench

  ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
  else begin
    fail_count++;
    $error("wb_ack_o high for more than one cycle");
  end

  ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i))
  else begin
    fail_count++;
    $error("wb_ack_o outside a bus cycle");
  end

  strobe_onehot: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0({fm_ren_o, fm_wen_o, fm_program_o}))
  else begin
    fail_count++;
    $error("more than one flash command strobe");
  end

  strobe_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (fm_ren_o || fm_wen_o || fm_program_o || fm_pagestatus_o) |=>
      !(fm_ren_o || fm_wen_o || fm_program_o || fm_pagestatus_o))
  else begin
    fail_count++;
    $error("flash strobe longer than one cycle");
  end

  // program targets the page the dirty register showed
  program_page: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (fm_program_o && $past(dirty_i)) |->
      (fm_addr_o[`FC_PAGE_LSB +: `FC_PAGE_BITS] == $past(dirty_page_i)))
  else begin
    fail_count++;
    $error("program address is not the dirty page");
  end

endmodule

bind flash_ctrl_top flash_ctrl_asserts u_asserts (
  .*,
  .dirty_i      (u_req_if.dirty),
  .dirty_page_i (u_req_if.dirty_page)
);

`default_nettype wire

// File: tests/flash_macro_model.sv
`timescale 1ns/1ps
`default_nettype none

module flash_macro_model (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [16:0] addr_i,
  input  logic [15:0] wd_i,
  input  logic        ren_i,
  input  logic        wen_i,
  input  logic        program_i,
  input  logic        pagestatus_i,
  input  logic        err_inject_i,  // programs fail while set
  output logic [15:0] rd_o,
  output logic        busy_o,
  output logic [1:0]  status_o,
  output int          prog_count_o,
  output logic [16:0] last_prog_o
);

  logic [15:0] mem [0:65535];
  logic [15:0] page_buf [0:63];
  logic [9:0]  buf_page;
  logic        buf_valid;
  logic [31:0] lcg_state;
  int          busy_cnt;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // unique per word, since 7 is odd
  function automatic logic [15:0] fill_word(input logic [15:0] a);
    return (a * 16'd7) ^ 16'h3c5a;
  endfunction

  task automatic load_page(input logic [9:0] pg);
    int k;
    if (!buf_valid || buf_page != pg) begin
      for (k = 0; k < 64; k++) begin
        page_buf[k] = mem[{pg, k[5:0]}];
      end
      buf_page  = pg;
      buf_valid = 1'b1;
    end
  endtask

  initial begin : fill_array
    int i;
    for (i = 0; i < 65536; i++) begin
      mem[i] = fill_word(i[15:0]);
    end
  end

  always @(posedge clk_i) begin : model_seq
    logic [31:0] nxt;
    logic [9:0]  pg;
    logic [5:0]  ofs;
    int          j;
    nxt = lcg_next(lcg_state);
    pg  = addr_i[15:6];
    ofs = addr_i[5:0];
    if (!rst_n_i) begin
      lcg_state    <= 32'd55;
      busy_cnt     <= 0;
      busy_o       <= 1'b0;
      status_o     <= 2'b00;
      rd_o         <= '0;
      prog_count_o <= 0;
      last_prog_o  <= '0;
      buf_valid    = 1'b0;
    end else begin
      if (ren_i || wen_i || program_i) begin
        lcg_state <= nxt;
        busy_cnt  <= 1 + nxt[17:16];  // 1 to 4 busy cycles
        busy_o    <= 1'b1;
        status_o  <= (program_i && err_inject_i) ? 2'b01 : 2'b00;
      end else if (busy_cnt > 1) begin
        busy_cnt <= busy_cnt - 1;
      end else begin
        busy_cnt <= 0;
        busy_o   <= 1'b0;
      end
      if (pagestatus_i) begin
        rd_o <= 16'hc000 | {6'b0, pg};  // page status reply
      end else if (ren_i) begin
        load_page(pg);
        rd_o <= page_buf[ofs];
      end
      if (wen_i) begin
        load_page(pg);
        page_buf[ofs] = wd_i;
      end
      if (program_i) begin
        if (!err_inject_i) begin
          for (j = 0; j < 64; j++) begin
            mem[{pg, j[5:0]}] = page_buf[j];
          end
        end
        prog_count_o <= prog_count_o + 1;
        last_prog_o  <= addr_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD_NS = 20;  // 40 ns clock
  localparam int RESET_CYCLES   = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #5 rst_o = 1'b0;  // released off the edge like the other inputs
  end

endmodule

`default_nettype wire

// File: verilog/flash_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_defines.svh"

module flash_ctrl_top (
  // wishbone slave
  input  logic                    wb_clk_i,
  input  logic                    wb_rst_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [`FC_WB_ADR_W-1:0] wb_adr_i,
  input  logic [`FC_DATA_W-1:0]   wb_dat_i,
  output logic [`FC_DATA_W-1:0]   wb_dat_o,
  output logic                    wb_ack_o,
  // flash macro
  output logic                    fm_clk_o,
  output logic                    fm_reset_o,
  output logic [`FC_FM_ADR_W-1:0] fm_addr_o,
  output logic [`FC_DATA_W-1:0]   fm_wd_o,
  output logic                    fm_ren_o,
  output logic                    fm_wen_o,
  output logic                    fm_program_o,
  output logic                    fm_pagestatus_o,
  input  logic [`FC_DATA_W-1:0]   fm_rd_i,
  input  logic                    fm_busy_i,
  input  logic [1:0]              fm_status_i
);

  flash_req_if u_req_if ();

  assign fm_clk_o = wb_clk_i;  // macro runs on the bus clock

  wb_reg_decode u_decode (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .fm_rd_i   (fm_rd_i),
    .fm_busy_i (fm_busy_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .req_if    (u_req_if.decode)
  );

  flash_sequencer u_seq (
    .wb_clk_i        (wb_clk_i),
    .wb_rst_i        (wb_rst_i),
    .fm_busy_i       (fm_busy_i),
    .fm_status_i     (fm_status_i),
    .req_if          (u_req_if.seq),
    .fm_addr_o       (fm_addr_o),
    .fm_wd_o         (fm_wd_o),
    .fm_ren_o        (fm_ren_o),
    .fm_wen_o        (fm_wen_o),
    .fm_program_o    (fm_program_o),
    .fm_pagestatus_o (fm_pagestatus_o),
    .fm_reset_o      (fm_reset_o)
  );

endmodule

`default_nettype wire

// File: verilog/flash_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_defines.svh"

module flash_sequencer (
  input  logic                    wb_clk_i,
  input  logic                    wb_rst_i,
  input  logic                    fm_busy_i,
  input  logic [1:0]              fm_status_i,
  flash_req_if.seq                req_if,
  output logic [`FC_FM_ADR_W-1:0] fm_addr_o,
  output logic [`FC_DATA_W-1:0]   fm_wd_o,
  output logic                    fm_ren_o,
  output logic                    fm_wen_o,
  output logic                    fm_program_o,
  output logic                    fm_pagestatus_o,
  output logic                    fm_reset_o
);

  flash_side_pkg::seq_state_e state_q;
  logic                       blank_q;       // ignore busy right after a strobe
  logic                       ren_q;
  logic                       wen_q;
  logic                       prog_q;
  logic                       pstat_q;
  logic                       done_q;
  logic                       dirty_q;
  logic [`FC_PAGE_BITS-1:0]   dirty_page_q;  // page held in the macro buffer
  logic [2:0]                 last_status_q;
  logic                       then_write_q;  // program precedes a write, else a read
  logic                       sync_only_q;
  logic                       status_rd_q;   // current read is a page-status query

  logic [`FC_PAGE_BITS-1:0]   req_page;
  logic                       page_miss;
  logic                       phase_end;
  logic                       status_ok;
  logic [`FC_FM_ADR_W-1:0]    prog_base;

  assign req_page  = req_if.addr[`FC_PAGE_LSB +: `FC_PAGE_BITS];
  assign page_miss = dirty_q && (dirty_page_q != req_page);
  assign phase_end = ~blank_q & ~fm_busy_i;
  assign status_ok = (fm_status_i == flash_side_pkg::FM_OK);
  assign prog_base = {{(`FC_FM_ADR_W-`FC_PAGE_BITS-`FC_PAGE_LSB){1'b0}},
                      dirty_page_q, {`FC_PAGE_LSB{1'b0}}};

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q       <= flash_side_pkg::SEQ_IDLE;
      blank_q       <= 1'b0;
      ren_q         <= 1'b0;
      wen_q         <= 1'b0;
      prog_q        <= 1'b0;
      pstat_q       <= 1'b0;
      done_q        <= 1'b0;
      dirty_q       <= 1'b0;
      dirty_page_q  <= '0;
      last_status_q <= flash_side_pkg::LAST_STATUS_RESET;
      then_write_q  <= 1'b0;
      sync_only_q   <= 1'b0;
      status_rd_q   <= 1'b0;
    end else begin
      ren_q   <= 1'b0;  // strobes and done are single cycle
      wen_q   <= 1'b0;
      prog_q  <= 1'b0;
      pstat_q <= 1'b0;
      done_q  <= 1'b0;
      blank_q <= 1'b0;
      case (state_q)
        flash_side_pkg::SEQ_IDLE: begin
          if (req_if.req) begin
            blank_q <= 1'b1;
            case (req_if.kind)
              wb_side_pkg::REQ_PAGE_STATUS: begin
                ren_q       <= 1'b1;
                pstat_q     <= 1'b1;
                status_rd_q <= 1'b1;
                state_q     <= flash_side_pkg::SEQ_READ;
              end
              wb_side_pkg::REQ_SYNC: begin
                prog_q      <= 1'b1;  // even when clean
                sync_only_q <= 1'b1;
                state_q     <= flash_side_pkg::SEQ_PROGRAM;
              end
              wb_side_pkg::REQ_WRITE: begin
                if (page_miss) begin
                  prog_q       <= 1'b1;  // commit old page first
                  sync_only_q  <= 1'b0;
                  then_write_q <= 1'b1;
                  state_q      <= flash_side_pkg::SEQ_PROGRAM;
                end else begin
                  wen_q   <= 1'b1;
                  state_q <= flash_side_pkg::SEQ_WRITE;
                end
              end
              default: begin  // plain read
                status_rd_q <= 1'b0;
                if (page_miss) begin
                  prog_q       <= 1'b1;
                  sync_only_q  <= 1'b0;
                  then_write_q <= 1'b0;
                  state_q      <= flash_side_pkg::SEQ_PROGRAM;
                end else begin
                  ren_q   <= 1'b1;
                  state_q <= flash_side_pkg::SEQ_READ;
                end
              end
            endcase
          end
        end
        flash_side_pkg::SEQ_PROGRAM: begin
          if (phase_end) begin
            last_status_q <= {1'b0, fm_status_i};
            if (status_ok) begin
              dirty_q <= 1'b0;  // failed program keeps the page dirty
            end
            if (sync_only_q) begin
              done_q  <= 1'b1;
              state_q <= flash_side_pkg::SEQ_IDLE;
            end else if (then_write_q) begin
              wen_q   <= 1'b1;
              blank_q <= 1'b1;
              state_q <= flash_side_pkg::SEQ_WRITE;
            end else begin
              ren_q   <= 1'b1;
              blank_q <= 1'b1;
              state_q <= flash_side_pkg::SEQ_READ;
            end
          end
        end
        flash_side_pkg::SEQ_READ: begin
          if (phase_end) begin
            last_status_q <= {1'b0, fm_status_i};
            done_q        <= 1'b1;
            state_q       <= flash_side_pkg::SEQ_IDLE;
            // a clean buffer now holds the page just read
            if (status_ok && !status_rd_q && !dirty_q) begin
              dirty_page_q <= req_page;
            end
          end
        end
        flash_side_pkg::SEQ_WRITE: begin
          if (phase_end) begin
            last_status_q <= {1'b0, fm_status_i};
            done_q        <= 1'b1;
            state_q       <= flash_side_pkg::SEQ_IDLE;
            if (status_ok) begin
              dirty_q      <= 1'b1;
              dirty_page_q <= req_page;
            end
          end
        end
      endcase
    end
  end

  assign fm_addr_o       = (state_q == flash_side_pkg::SEQ_PROGRAM) ? prog_base : req_if.addr;
  assign fm_wd_o         = req_if.wdata;
  assign fm_ren_o        = ren_q;
  assign fm_wen_o        = wen_q;
  assign fm_program_o    = prog_q;
  assign fm_pagestatus_o = pstat_q;
  assign fm_reset_o      = ~wb_rst_i;  // macro reset is active low

  assign req_if.done        = done_q;
  assign req_if.dirty       = dirty_q;
  assign req_if.dirty_page  = dirty_page_q;
  assign req_if.last_status = last_status_q;

endmodule

`default_nettype wire

// File: verilog/wb_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_defines.svh"

module wb_reg_decode (
  input  logic                    wb_clk_i,
  input  logic                    wb_rst_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [`FC_WB_ADR_W-1:0] wb_adr_i,
  input  logic [`FC_DATA_W-1:0]   wb_dat_i,
  input  logic [`FC_DATA_W-1:0]   fm_rd_i,
  input  logic                    fm_busy_i,
  output logic [`FC_DATA_W-1:0]   wb_dat_o,
  output logic                    wb_ack_o,
  flash_req_if.decode             req_if
);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_WAIT = 1'b1;  // flash request outstanding

  localparam logic [`FC_WB_ADR_W-1:0] REG_WINDOW = `FC_REG_WINDOW;

  logic                       state_q;
  logic                       req_q;
  wb_side_pkg::req_kind_e     kind_q;
  wb_side_pkg::rd_src_e       rd_src_q;
  logic [`FC_WB_ADR_W-1:0]    status_addr_q;  // address for page-status query

  logic                       wb_trans;
  logic                       fm_sel;
  logic [`FC_WB_ADR_W-1:0]    flash_adr;
  logic [5:0]                 reg_ofs;
  logic                       latch_status_addr;

  assign wb_trans  = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // no new transfer during ack
  assign fm_sel    = wb_adr_i >= REG_WINDOW;
  assign flash_adr = wb_adr_i - REG_WINDOW;
  assign reg_ofs   = wb_adr_i[5:0];

  assign latch_status_addr = (state_q == ST_IDLE) && wb_trans && !fm_sel &&
                             (reg_ofs == `FC_REG_PAGE_STATUS) && wb_we_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q  <= ST_IDLE;
      wb_ack_o <= 1'b0;
      req_q    <= 1'b0;
      kind_q   <= wb_side_pkg::REQ_READ;
      rd_src_q <= wb_side_pkg::RD_SRC_ZERO;
    end else begin
      wb_ack_o <= 1'b0;  // single cycle pulses
      req_q    <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (wb_trans && fm_sel) begin
            req_q    <= 1'b1;
            rd_src_q <= wb_side_pkg::RD_SRC_FLASH;
            state_q  <= ST_WAIT;
            if (wb_we_i) begin
              kind_q <= wb_side_pkg::REQ_WRITE;
            end else begin
              kind_q <= wb_side_pkg::REQ_READ;
            end
          end else if (wb_trans) begin
            case (reg_ofs)
              `FC_REG_FLASH_STATUS: begin
                rd_src_q <= wb_side_pkg::RD_SRC_STATUS;
                wb_ack_o <= 1'b1;
              end
              `FC_REG_PAGE_STATUS: begin
                if (wb_we_i) begin
                  rd_src_q <= wb_side_pkg::RD_SRC_ZERO;  // address latched below
                  wb_ack_o <= 1'b1;
                end else begin
                  req_q    <= 1'b1;
                  kind_q   <= wb_side_pkg::REQ_PAGE_STATUS;
                  rd_src_q <= wb_side_pkg::RD_SRC_FLASH;  // reply comes on fm_rd_i
                  state_q  <= ST_WAIT;
                end
              end
              `FC_REG_DIRTY_PAGE: begin
                rd_src_q <= wb_side_pkg::RD_SRC_DIRTY;
                wb_ack_o <= 1'b1;
              end
              `FC_REG_DIRTY_SYNC: begin
                rd_src_q <= wb_side_pkg::RD_SRC_ZERO;
                if (wb_we_i) begin
                  req_q   <= 1'b1;
                  kind_q  <= wb_side_pkg::REQ_SYNC;
                  state_q <= ST_WAIT;
                end else begin
                  wb_ack_o <= 1'b1;
                end
              end
              default: begin
                rd_src_q <= wb_side_pkg::RD_SRC_ZERO;  // unmapped register
                wb_ack_o <= 1'b1;
              end
            endcase
          end
        end
        ST_WAIT: begin
          if (req_if.done) begin
            wb_ack_o <= 1'b1;
            state_q  <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (latch_status_addr) begin
      status_addr_q <= wb_dat_i;
    end
  end

  assign req_if.req   = req_q;
  assign req_if.kind  = kind_q;
  assign req_if.wdata = wb_dat_i;  // master holds data until ack
  assign req_if.addr  = (kind_q == wb_side_pkg::REQ_PAGE_STATUS) ?
                        {{(`FC_FM_ADR_W-`FC_WB_ADR_W){1'b0}}, status_addr_q} :
                        {{(`FC_FM_ADR_W-`FC_WB_ADR_W){1'b0}}, flash_adr};

  always_comb begin
    case (rd_src_q)
      wb_side_pkg::RD_SRC_FLASH:  wb_dat_o = fm_rd_i;
      wb_side_pkg::RD_SRC_STATUS: wb_dat_o = {7'b0, fm_busy_i, 5'b0, req_if.last_status};
      wb_side_pkg::RD_SRC_DIRTY:  wb_dat_o = req_if.dirty ?
                                  {{(`FC_DATA_W-`FC_PAGE_BITS){1'b0}}, req_if.dirty_page} :
                                  {`FC_DATA_W{1'b1}};  // clean buffer
      default:                    wb_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/flash_req_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_defines.svh"

interface flash_req_if;

  // decode stage to sequencer
  logic                       req;    // one cycle pulse
  wb_side_pkg::req_kind_e     kind;
  logic [`FC_FM_ADR_W-1:0]    addr;   // held until done
  logic [`FC_DATA_W-1:0]      wdata;  // held until done

  // sequencer back to decode stage
  logic                       done;   // one cycle pulse
  logic                       dirty;
  logic [`FC_PAGE_BITS-1:0]   dirty_page;
  logic [2:0]                 last_status;

  modport decode (
    output req, kind, addr, wdata,
    input  done, dirty, dirty_page, last_status
  );

  modport seq (
    input  req, kind, addr, wdata,
    output done, dirty, dirty_page, last_status
  );

endinterface

`default_nettype wire

// File: verilog/flash_side_pkg.sv
`default_nettype none

package flash_side_pkg;

  // sequencer phase
  typedef enum logic [1:0] {
    SEQ_IDLE    = 2'd0,
    SEQ_READ    = 2'd1,  // read or page-status read in progress
    SEQ_WRITE   = 2'd2,  // buffer write in progress
    SEQ_PROGRAM = 2'd3   // page commit in progress
  } seq_state_e;

  // status code returned by the macro on success
  localparam logic [1:0] FM_OK = 2'b00;

  // last status before any operation has completed
  localparam logic [2:0] LAST_STATUS_RESET = 3'b111;

endpackage

`default_nettype wire

// File: verilog/wb_side_pkg.sv
`default_nettype none

package wb_side_pkg;

  // source of wb_dat_o, registered together with ack
  typedef enum logic [1:0] {
    RD_SRC_FLASH  = 2'd0,  // flash read data
    RD_SRC_STATUS = 2'd1,  // busy and last status
    RD_SRC_DIRTY  = 2'd2,  // dirty page word
    RD_SRC_ZERO   = 2'd3   // nothing to return
  } rd_src_e;

  // operation handed from the decode stage to the sequencer
  typedef enum logic [1:0] {
    REQ_READ        = 2'd0,  // read one flash word
    REQ_WRITE       = 2'd1,  // write one word into the page buffer
    REQ_PAGE_STATUS = 2'd2,  // query page status at the latched address
    REQ_SYNC        = 2'd3   // program the buffered page
  } req_kind_e;

endpackage

`default_nettype wire

// File: verilog/flash_ctrl_defines.svh
`ifndef FLASH_CTRL_DEFINES_SVH
`define FLASH_CTRL_DEFINES_SVH

// register offsets inside the register window
`define FC_REG_FLASH_STATUS 6'd0  // busy line and last flash status
`define FC_REG_PAGE_STATUS  6'd1  // write latches address, read queries
`define FC_REG_DIRTY_PAGE   6'd2  // dirty page index, all ones when clean
`define FC_REG_DIRTY_SYNC   6'd3  // write forces a program

// word addresses below this are registers, the rest is flash
`define FC_REG_WINDOW 64

// page geometry of the flash word address
`define FC_PAGE_LSB  6   // 64 words per page
`define FC_PAGE_BITS 10  // 1024 pages

// bus widths
`define FC_DATA_W   16
`define FC_WB_ADR_W 16
`define FC_FM_ADR_W 17

`endif
